// File: all.f
+incdir+.
soc_pkg.sv
soc_bus_if.sv
baud_timer.sv
bus_ctrl.sv
gpio_regs.sv
uart_tx.sv
soc_top.sv
soc_chk.sv
tb_soc.sv

// File: Makefile
TOP = tb_soc

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_soc.sv
// Directed tests with one command in flight; assumes SOC_BAUD_DIV even and the defs offsets
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc import soc_pkg::*;;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 4;
    localparam int CMD_CYCLES   = 14;                   // Worst command incl. back-pressure
    localparam int N_CMDS       = 48;
    localparam int FRAME_CYCLES = 10 * `SOC_BAUD_DIV + 8;
    localparam int N_FRAMES     = 2;
    localparam int LIMIT_CYCLES = RESET_CYCLES + N_CMDS * CMD_CYCLES
                                  + N_FRAMES * FRAME_CYCLES + 200;

    localparam soc_addr_t ADDR_OUT  = soc_addr_t'(`SOC_ADDR_GPIO_OUT);
    localparam soc_addr_t ADDR_DIR  = soc_addr_t'(`SOC_ADDR_GPIO_DIR);
    localparam soc_addr_t ADDR_IN   = soc_addr_t'(`SOC_ADDR_GPIO_IN);
    localparam soc_addr_t ADDR_DATA = soc_addr_t'(`SOC_ADDR_UART_DATA);
    localparam soc_addr_t ADDR_STAT = soc_addr_t'(`SOC_ADDR_UART_STAT);

    logic                   i_sys_clk;
    logic                   i_reset;
    logic                   i_cmd_valid;
    logic                   o_cmd_ready;
    soc_addr_t              i_cmd_addr;
    logic                   i_cmd_write;
    soc_word_t              i_cmd_wdata;
    logic                   o_rsp_valid;
    logic                   i_rsp_ready;
    soc_word_t              o_rsp_data;
    logic                   o_rsp_err;
    logic [`SOC_GPIO_W-1:0] i_gpio;
    logic [`SOC_GPIO_W-1:0] o_gpio;
    logic [`SOC_GPIO_W-1:0] o_gpio_dir;
    logic                   o_uart_td;

    logic [15:0]            lfsr_q = 16'd56;            // Stimulus LFSR state
    logic [`SOC_GPIO_W-1:0] exp_out;                    // Expected output register
    logic [`SOC_GPIO_W-1:0] exp_dir;                    // Expected direction register

    soc_top DUT (.*);

    bind bus_ctrl soc_chk chk0 (
        .i_sys_clk  (i_sys_clk),
        .i_reset    (i_reset),
        .i_sel      (bus.sel),
        .i_enable   (bus.enable),
        .i_cmd_ready(o_cmd_ready),
        .i_rsp_valid(o_rsp_valid),
        .i_rsp_ready(i_rsp_ready),
        .i_rsp_data (o_rsp_data),
        .i_rsp_err  (o_rsp_err)
    );

    initial
    begin
        i_sys_clk = 1'b0;
        forever #(CLK_NS / 2) i_sys_clk = ~i_sys_clk;
    end

    // Watchdog sized from the command and frame counts
    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge i_sys_clk);
        $display("Timeout: run exceeded %0d clock cycles", LIMIT_CYCLES);
        abort_run("watchdog expired");
    end

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    //////////////////////////////////////////////////
    // LFSR with taps 16 14 13 11
    //////////////////////////////////////////////////
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic soc_word_t rand_bits(input int n);
        soc_word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[`SOC_DATA_W-2:0], lfsr_step()};     // One step per bit
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input string what, input soc_word_t got, input soc_word_t exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_err(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run("error flag mismatch");
        end
    endtask

    task automatic check_pins(input string what, input logic [`SOC_GPIO_W-1:0] got,
                              input logic [`SOC_GPIO_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
            abort_run("GPIO pin mismatch");
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
            abort_run("UART byte mismatch");
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run("cycle count mismatch");
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run("control level mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge i_sys_clk);
        #1;                                             // Drive and sample point
    endtask

    //////////////////////////////////////////////////
    // Host command with optional back-pressure
    //////////////////////////////////////////////////
    task automatic bus_cmd(input soc_addr_t addr, input logic wr, input soc_word_t wdata,
                           input logic use_bp, output soc_word_t rdata, output logic err);
        int bp;
        int cyc;
        bp = use_bp ? 1 + int'(rand_bits(2)) : 0;
        next_cycle();
        i_cmd_valid = 1'b1;
        i_cmd_addr  = addr;
        i_cmd_write = wr;
        i_cmd_wdata = wdata;
        i_rsp_ready = (bp == 0);                        // Held high when no back-pressure
        cyc = 0;
        while (!o_cmd_ready)
        begin
            next_cycle();
            cyc++;
            if (cyc > CMD_CYCLES)
            begin
                $display("Timeout: command to 0x%h never accepted", addr);
                abort_run("command not accepted");
            end
        end
        next_cycle();                                   // Accepted on this edge
        i_cmd_valid = 1'b0;
        cyc = 0;
        while (!o_rsp_valid && cyc <= CMD_CYCLES)
        begin
            next_cycle();
            cyc++;
        end
        check_count("response latency", cyc, 3);
        repeat (bp)
        begin
            check_level("cmd ready under back-pressure", o_cmd_ready, 1'b0);
            next_cycle();
        end
        rdata       = o_rsp_data;
        err         = o_rsp_err;
        i_rsp_ready = 1'b1;
        next_cycle();                                   // Response taken
        i_rsp_ready = 1'b0;
        check_level("rsp valid after transfer", o_rsp_valid, 1'b0);
        check_level("cmd ready after transfer", o_cmd_ready, 1'b1);
    endtask

    task automatic write_and_check(input soc_addr_t addr, input soc_word_t data,
                                   input logic exp_err);
        soc_word_t rd;
        logic      er;
        bus_cmd(addr, 1'b1, data, 1'b1, rd, er);
        check_err($sformatf("write 0x%h error flag", addr), er, exp_err);
    endtask

    task automatic read_and_check(input soc_addr_t addr, input soc_word_t exp_data,
                                  input logic exp_err);
        soc_word_t rd;
        logic      er;
        bus_cmd(addr, 1'b0, '0, 1'b1, rd, er);
        check_word($sformatf("read 0x%h data", addr), rd, exp_data);
        check_err($sformatf("read 0x%h error flag", addr), er, exp_err);
    endtask

    // Serial monitor sampling mid-bit from the first falling edge
    task automatic capture_frame(output logic [7:0] b);
        int cyc;
        cyc = 0;
        while (o_uart_td)
        begin
            next_cycle();
            cyc++;
            if (cyc > 4 * CMD_CYCLES)
            begin
                $display("Timeout: no start bit seen on the UART line");
                abort_run("no UART frame");
            end
        end
        repeat (`SOC_BAUD_DIV / 2) next_cycle();
        check_level("start bit", o_uart_td, 1'b0);
        for (int i = 0; i < 8; i++)
        begin
            repeat (`SOC_BAUD_DIV) next_cycle();
            b[i] = o_uart_td;                           // LSB first
        end
        repeat (`SOC_BAUD_DIV) next_cycle();
        check_level("stop bit", o_uart_td, 1'b1);
        repeat (`SOC_BAUD_DIV / 2) next_cycle();        // Stop bit over
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic reset_values();
        check_level("cmd ready after reset", o_cmd_ready, 1'b1);
        check_level("rsp valid after reset", o_rsp_valid, 1'b0);
        check_level("uart line after reset", o_uart_td, 1'b1);
        check_pins("o_gpio after reset", o_gpio, '0);
        check_pins("o_gpio_dir after reset", o_gpio_dir, '0);
    endtask

    task automatic gpio_access();
        soc_word_t w;
        for (int i = 0; i < 3; i++)
        begin
            w       = rand_bits(32);                    // Upper bits are dropped
            exp_out = w[`SOC_GPIO_W-1:0];
            write_and_check(ADDR_OUT, w, 1'b0);
            check_pins("o_gpio", o_gpio, exp_out);
            w       = rand_bits(32);
            exp_dir = w[`SOC_GPIO_W-1:0];
            write_and_check(ADDR_DIR, w, 1'b0);
            check_pins("o_gpio_dir", o_gpio_dir, exp_dir);
            read_and_check(ADDR_OUT, soc_word_t'(exp_out), 1'b0);
            read_and_check(ADDR_DIR, soc_word_t'(exp_dir), 1'b0);
        end
        for (int i = 0; i < 2; i++)
        begin
            w      = rand_bits(`SOC_GPIO_W);
            i_gpio = w[`SOC_GPIO_W-1:0];
            read_and_check(ADDR_IN, w, 1'b0);
        end
    endtask

    task automatic error_responses();
        soc_addr_t holes [6] = '{8'h0C, 8'h18, 8'h1C, 8'h20, 8'h80, 8'hE4};
        write_and_check(ADDR_IN, rand_bits(32), 1'b1);      // Read only
        read_and_check(ADDR_IN, soc_word_t'(i_gpio), 1'b0);
        write_and_check(ADDR_STAT, 32'h1, 1'b1);
        read_and_check(ADDR_STAT, '0, 1'b0);
        foreach (holes[i])
        begin
            write_and_check(holes[i], rand_bits(32), 1'b1);
            read_and_check(holes[i], '0, 1'b1);
        end
        check_pins("o_gpio after bad writes", o_gpio, exp_out);
        check_pins("o_gpio_dir after bad writes", o_gpio_dir, exp_dir);
        read_and_check(ADDR_OUT, soc_word_t'(exp_out), 1'b0);
        read_and_check(ADDR_DIR, soc_word_t'(exp_dir), 1'b0);
    endtask

    task automatic uart_frame_shape();
        soc_word_t  w;
        logic [7:0] got;
        w = rand_bits(32);
        fork
            capture_frame(got);
            write_and_check(ADDR_DATA, w, 1'b0);
        join
        check_byte("frame byte", got, w[7:0]);
        read_and_check(ADDR_DATA, soc_word_t'(w[7:0]), 1'b0);
        check_level("uart line after frame", o_uart_td, 1'b1);
    endtask

    task automatic uart_busy_rules();
        soc_word_t  first;
        soc_word_t  second;
        logic [7:0] got;
        first  = rand_bits(32);
        second = ~first;
        fork
            capture_frame(got);
            begin
                write_and_check(ADDR_DATA, first, 1'b0);
                read_and_check(ADDR_STAT, 32'h1, 1'b0);         // Busy
                write_and_check(ADDR_DATA, second, 1'b1);       // Dropped
                read_and_check(ADDR_DATA, soc_word_t'(first[7:0]), 1'b0);
                read_and_check(ADDR_STAT, 32'h1, 1'b0);
            end
        join
        check_byte("frame byte with second write", got, first[7:0]);
        read_and_check(ADDR_STAT, '0, 1'b0);                   // Idle again
    endtask

    task automatic handshake_timing();
        soc_word_t rd;
        logic      er;
        for (int i = 0; i < 4; i++)
        begin
            bus_cmd(ADDR_OUT, 1'b0, '0, 1'b0, rd, er);          // Ready held high
            check_word("read without back-pressure", rd, soc_word_t'(exp_out));
            check_err("read without back-pressure", er, 1'b0);
            bus_cmd(ADDR_DIR, 1'b0, '0, 1'b1, rd, er);
            check_word("read under back-pressure", rd, soc_word_t'(exp_dir));
            check_err("read under back-pressure", er, 1'b0);
        end
    endtask

    initial
    begin
        i_reset     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_addr  = '0;
        i_cmd_write = 1'b0;
        i_cmd_wdata = '0;
        i_rsp_ready = 1'b0;
        i_gpio      = '0;
        exp_out     = '0;
        exp_dir     = '0;
        repeat (RESET_CYCLES) @(posedge i_sys_clk);
        #1;
        i_reset = 1'b0;
        reset_values();
        gpio_access();
        error_responses();
        uart_frame_shape();
        uart_busy_rules();
        handshake_timing();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: soc_chk.sv
// Bound to bus_ctrl; checks phase order and host handshake rules, reset cycles are skipped
`timescale 1ns/1ps

module soc_chk import soc_pkg::*;
(
    input  logic        i_sys_clk,
    input  logic        i_reset,
    input  slot_t       i_sel,          // Peripheral bus select
    input  logic        i_enable,       // Access phase strobe
    input  logic        i_cmd_ready,
    input  logic        i_rsp_valid,
    input  logic        i_rsp_ready,
    input  soc_word_t   i_rsp_data,
    input  logic        i_rsp_err
);

    //////////////////////////////////////////////////
    // Peripheral bus phases
    //////////////////////////////////////////////////
    // Access only after a setup cycle to the same slave
    a_access_after_setup: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_enable |-> !$past(i_enable) && ($past(i_sel) == i_sel) && (i_sel != SLOT_NONE))
        else $error("enable high without a matching setup cycle");

    //////////////////////////////////////////////////
    // Host response handshake
    //////////////////////////////////////////////////
    a_rsp_held: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid)
        else $error("response valid dropped before transfer");

    a_rsp_stable: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_rsp_valid && !i_rsp_ready |=> $stable(i_rsp_data) && $stable(i_rsp_err))
        else $error("response fields changed while waiting");

    // One command in flight
    a_ready_excl: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        !(i_cmd_ready && i_rsp_valid))
        else $error("command ready together with response valid");

endmodule

// File: soc_top.sv
// Host port to GPIO and UART transmitter only; single clock, synchronous active-high reset
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top import soc_pkg::*;
(
    input  logic                    i_sys_clk,      // System clock
    input  logic                    i_reset,        // Synchronous, active high
    // Host command
    input  logic                    i_cmd_valid,
    output logic                    o_cmd_ready,
    input  soc_addr_t               i_cmd_addr,
    input  logic                    i_cmd_write,
    input  soc_word_t               i_cmd_wdata,
    // Host response
    output logic                    o_rsp_valid,
    input  logic                    i_rsp_ready,
    output soc_word_t               o_rsp_data,
    output logic                    o_rsp_err,      // Unmapped, read only or busy
    // Pins
    input  logic [`SOC_GPIO_W-1:0]  i_gpio,
    output logic [`SOC_GPIO_W-1:0]  o_gpio,
    output logic [`SOC_GPIO_W-1:0]  o_gpio_dir,
    output logic                    o_uart_td
);

    soc_bus_if pbus ();                             // Internal peripheral bus

    //////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////
    bus_ctrl ctrl0 (
        .i_sys_clk  (i_sys_clk),
        .i_reset    (i_reset),
        .i_cmd_valid(i_cmd_valid),
        .o_cmd_ready(o_cmd_ready),
        .i_cmd_addr (i_cmd_addr),
        .i_cmd_write(i_cmd_write),
        .i_cmd_wdata(i_cmd_wdata),
        .o_rsp_valid(o_rsp_valid),
        .i_rsp_ready(i_rsp_ready),
        .o_rsp_data (o_rsp_data),
        .o_rsp_err  (o_rsp_err),
        .bus        (pbus.ctrl)
    );

    // Offsets 0x00..0x0F
    gpio_regs gpio0 (
        .i_sys_clk  (i_sys_clk),
        .i_reset    (i_reset),
        .bus        (pbus.gpio),
        .i_gpio     (i_gpio),
        .o_gpio     (o_gpio),
        .o_gpio_dir (o_gpio_dir)
    );

    // Offsets 0x10..0x1F
    uart_tx uart0 (
        .i_sys_clk  (i_sys_clk),
        .i_reset    (i_reset),
        .bus        (pbus.uart),
        .o_uart_td  (o_uart_td)
    );

endmodule

// File: uart_tx.sv
// 8N1 transmitter only, no FIFO; data write while busy is dropped and flagged as an error
`timescale 1ns/1ps
`include "soc_defs.svh"

module uart_tx import soc_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_reset,
    soc_bus_if.uart bus,
    output logic    o_uart_td       // Serial line, high when idle
);

    tx_state_t  state;
    logic [7:0] data_q;             // Last byte loaded
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic       td_q;
    logic       busy;
    logic       acc;                // Access cycle aimed at this slave
    logic       load;               // Frame start
    logic       tick;

    assign busy = (state != TX_IDLE);
    assign acc  = bus.enable && (bus.sel == SLOT_UART);
    assign load = acc && bus.write && (bus.addr == `SOC_ADDR_UART_DATA) && !busy;

    baud_timer baud0 (
        .i_sys_clk  (i_sys_clk),
        .i_reset    (i_reset),
        .i_enable   (busy),
        .i_restart  (load),
        .o_tick     (tick)
    );

    //////////////////////////////////////////////////
    // Register read and error return
    //////////////////////////////////////////////////
    always_comb
    begin
        bus.uart_rdata = '0;
        bus.uart_err   = 1'b0;
        if (acc)
        begin
            case (bus.addr)
                `SOC_ADDR_UART_DATA:
                begin
                    bus.uart_rdata = soc_word_t'(data_q);
                    bus.uart_err   = bus.write && busy;     // Frame still on the line
                end
                `SOC_ADDR_UART_STAT:
                begin
                    bus.uart_rdata = soc_word_t'(busy);
                    bus.uart_err   = bus.write;             // Read only
                end
                default: bus.uart_err = 1'b1;
            endcase
        end
    end

    // Frame FSM, line changes on baud ticks
    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            state   <= TX_IDLE;
            td_q    <= 1'b1;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (load)
                    begin
                        state <= TX_START;
                        td_q  <= 1'b0;                      // Start bit
                    end
                end
                TX_START:
                begin
                    if (tick)
                    begin
                        state   <= TX_DATA;
                        td_q    <= shift_q[0];              // LSB first
                        bit_cnt <= '0;
                    end
                end
                TX_DATA:
                begin
                    if (tick)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            state <= TX_STOP;
                            td_q  <= 1'b1;                  // Stop bit
                        end
                        else
                        begin
                            td_q    <= shift_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP:
                begin
                    if (tick)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte payload
    always_ff @(posedge i_sys_clk)
    begin
        if (load)
        begin
            data_q  <= bus.wdata[7:0];
            shift_q <= bus.wdata[7:0];
        end
        else if (tick && (state == TX_START || state == TX_DATA))
            shift_q <= {1'b0, shift_q[7:1]};                // Next bit to bit 0
    end

    assign o_uart_td = td_q;

endmodule

// File: gpio_regs.sv
// Plain GPIO registers, no interrupts; pin input seen one cycle late through the sample register
`timescale 1ns/1ps
`include "soc_defs.svh"

module gpio_regs import soc_pkg::*;
(
    input  logic                    i_sys_clk,
    input  logic                    i_reset,
    soc_bus_if.gpio                 bus,
    input  logic [`SOC_GPIO_W-1:0]  i_gpio,
    output logic [`SOC_GPIO_W-1:0]  o_gpio,
    output logic [`SOC_GPIO_W-1:0]  o_gpio_dir
);

    logic [`SOC_GPIO_W-1:0] out_q;
    logic [`SOC_GPIO_W-1:0] dir_q;      // 1 means output
    logic [`SOC_GPIO_W-1:0] in_q;       // Pin sample
    logic                   acc;

    assign acc = bus.enable && (bus.sel == SLOT_GPIO);

    // Writes land at the edge closing the access cycle
    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            out_q <= '0;
            dir_q <= '0;
        end
        else if (acc && bus.write)
        begin
            if (bus.addr == `SOC_ADDR_GPIO_OUT)
                out_q <= bus.wdata[`SOC_GPIO_W-1:0];
            if (bus.addr == `SOC_ADDR_GPIO_DIR)
                dir_q <= bus.wdata[`SOC_GPIO_W-1:0];
        end
    end

    always_ff @(posedge i_sys_clk)
    begin
        in_q <= i_gpio;                 // Every clock
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////
    always_comb
    begin
        bus.gpio_rdata = '0;
        bus.gpio_err   = 1'b0;
        if (acc)
        begin
            case (bus.addr)
                `SOC_ADDR_GPIO_OUT: bus.gpio_rdata = soc_word_t'(out_q);
                `SOC_ADDR_GPIO_DIR: bus.gpio_rdata = soc_word_t'(dir_q);
                `SOC_ADDR_GPIO_IN:
                begin
                    bus.gpio_rdata = soc_word_t'(in_q);
                    bus.gpio_err   = bus.write;     // Read only
                end
                default: bus.gpio_err = 1'b1;       // Hole in the map
            endcase
        end
    end

    assign o_gpio     = out_q;
    assign o_gpio_dir = dir_q;

endmodule

// File: bus_ctrl.sv
// One command in flight; response valid 3 cycles after acceptance, unmapped address gives error
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_ctrl import soc_pkg::*;
(
    input  logic        i_sys_clk,
    input  logic        i_reset,
    input  logic        i_cmd_valid,
    output logic        o_cmd_ready,
    input  soc_addr_t   i_cmd_addr,
    input  logic        i_cmd_write,
    input  soc_word_t   i_cmd_wdata,
    output logic        o_rsp_valid,
    input  logic        i_rsp_ready,
    output soc_word_t   o_rsp_data,
    output logic        o_rsp_err,
    soc_bus_if.ctrl     bus
);

    bus_state_t state;
    logic       cmd_held;           // Command captured, decode pending
    slot_t      slot_q;             // Registered decode
    slot_t      slot_d;
    soc_addr_t  addr_q;
    logic       write_q;
    soc_word_t  wdata_q;
    soc_word_t  rsp_data_q;
    logic       rsp_err_q;

    // Upper bits must be zero, next bit picks GPIO or UART
    always_comb
    begin
        if (addr_q[`SOC_ADDR_W-1:`SOC_OFS_W] != '0)
            slot_d = SLOT_NONE;
        else if (addr_q[`SOC_OFS_W-1])
            slot_d = SLOT_UART;
        else
            slot_d = SLOT_GPIO;
    end

    //////////////////////////////////////////////////
    // Phase sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            state    <= BUS_IDLE;
            cmd_held <= 1'b0;
            slot_q   <= SLOT_NONE;
        end
        else
        begin
            case (state)
                BUS_IDLE:
                begin
                    if (i_cmd_valid && o_cmd_ready)
                        cmd_held <= 1'b1;           // Decode cycle follows
                    else if (cmd_held)
                    begin
                        cmd_held <= 1'b0;
                        slot_q   <= slot_d;
                        state    <= BUS_SETUP;
                    end
                end
                BUS_SETUP:  state <= BUS_ACCESS;
                BUS_ACCESS: state <= BUS_RESP;
                BUS_RESP:
                begin
                    if (i_rsp_ready)
                        state <= BUS_IDLE;          // Host took the response
                end
                default:    state <= BUS_IDLE;
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge i_sys_clk)
    begin
        if (i_cmd_valid && o_cmd_ready)
        begin
            addr_q  <= i_cmd_addr;
            write_q <= i_cmd_write;
            wdata_q <= i_cmd_wdata;
        end
        if (state == BUS_ACCESS)
        begin
            case (slot_q)
                SLOT_GPIO:
                begin
                    rsp_data_q <= bus.gpio_rdata;
                    rsp_err_q  <= bus.gpio_err;
                end
                SLOT_UART:
                begin
                    rsp_data_q <= bus.uart_rdata;
                    rsp_err_q  <= bus.uart_err;
                end
                default:
                begin
                    rsp_data_q <= '0;           // Nothing mapped here
                    rsp_err_q  <= 1'b1;
                end
            endcase
        end
    end

    // Bus drive, sel only during a transfer
    assign bus.sel    = (state == BUS_SETUP || state == BUS_ACCESS) ? slot_q : SLOT_NONE;
    assign bus.enable = (state == BUS_ACCESS) && (slot_q != SLOT_NONE);
    assign bus.addr   = addr_q[`SOC_OFS_W-1:0];
    assign bus.write  = write_q;
    assign bus.wdata  = wdata_q;

    assign o_cmd_ready = (state == BUS_IDLE) && !cmd_held;
    assign o_rsp_valid = (state == BUS_RESP);
    assign o_rsp_data  = rsp_data_q;
    assign o_rsp_err   = rsp_err_q;

endmodule

// File: baud_timer.sv
// Tick every SOC_BAUD_DIV cycles while enabled; first tick one full bit period after enable
`timescale 1ns/1ps
`include "soc_defs.svh"

module baud_timer
(
    input  logic    i_sys_clk,
    input  logic    i_reset,
    input  logic    i_enable,       // Frame in progress
    input  logic    i_restart,      // Frame start
    output logic    o_tick          // Bit boundary
);

    localparam int CNT_W = $clog2(`SOC_BAUD_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset || !i_enable || i_restart)
            cnt <= CNT_W'(`SOC_BAUD_DIV - 1);   // Parked at full period
        else if (cnt == '0)
            cnt <= CNT_W'(`SOC_BAUD_DIV - 1);   // Reload on boundary
        else
            cnt <= cnt - 1'b1;
    end

    assign o_tick = i_enable && (cnt == '0);

endmodule

// File: soc_bus_if.sv
// Internal peripheral bus; slaves answer combinationally in the access cycle, no ready wire
`timescale 1ns/1ps
`include "soc_defs.svh"

interface soc_bus_if import soc_pkg::*;;

    slot_t                  sel;        // Target slave, valid in setup and access
    logic                   enable;     // High in the access cycle only
    logic [`SOC_OFS_W-1:0]  addr;       // Register offset
    logic                   write;
    soc_word_t              wdata;

    // Per-slave return fields
    soc_word_t              gpio_rdata;
    logic                   gpio_err;
    soc_word_t              uart_rdata;
    logic                   uart_err;

    modport ctrl (output sel, enable, addr, write, wdata,
                  input  gpio_rdata, gpio_err, uart_rdata, uart_err);

    modport gpio (input  sel, enable, addr, write, wdata,
                  output gpio_rdata, gpio_err);

    modport uart (input  sel, enable, addr, write, wdata,
                  output uart_rdata, uart_err);

endinterface

// File: soc_pkg.sv
// Types shared by RTL and testbench; widths follow soc_defs.svh and are fixed at compile time
`include "soc_defs.svh"

package soc_pkg;

    typedef logic [`SOC_DATA_W-1:0] soc_word_t;   // One data word
    typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;   // Host address

    // Controller phases
    typedef enum logic [1:0] {
        BUS_IDLE   = 2'd0,  // Waiting for a command
        BUS_SETUP  = 2'd1,  // sel valid, enable low
        BUS_ACCESS = 2'd2,  // sel valid, enable high
        BUS_RESP   = 2'd3   // Holding the response
    } bus_state_t;

    // Decoded slave
    typedef enum logic [1:0] {
        SLOT_NONE = 2'd0,
        SLOT_GPIO = 2'd1,
        SLOT_UART = 2'd2
    } slot_t;

    // UART frame phases
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage

// File: soc_defs.svh
// Widths, register offsets and baud divisor for the whole subsystem; offsets fit in SOC_OFS_W bits
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define SOC_ADDR_W          8       // Host address bits
`define SOC_DATA_W          32      // Data word bits
`define SOC_OFS_W           5       // Offset bits carried on the peripheral bus
`define SOC_GPIO_W          12      // GPIO pin count

// Clock cycles per UART bit
`define SOC_BAUD_DIV        8

//////////////////////////////////////////////////
// Register offsets, SOC_OFS_W bits wide
//////////////////////////////////////////////////
`define SOC_ADDR_GPIO_OUT   5'h00   // Output register
`define SOC_ADDR_GPIO_DIR   5'h04   // Direction register
`define SOC_ADDR_GPIO_IN    5'h08   // Sampled pins, read only
`define SOC_ADDR_UART_DATA  5'h10   // Transmit byte
`define SOC_ADDR_UART_STAT  5'h14   // Busy flag in bit 0, read only

`endif
